// File: Makefile
VERILATOR ?= verilator
TOP       := query_buffer_tb
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
SIM_ARGS  := +verilator+error+limit+1000
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: patch_addr_counter.sv
`timescale 1ns/1ps

module patch_addr_counter #(
  parameter int WIDTH = 10
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inc,
  output logic [WIDTH-1:0] ptr
);

  // top bit is the lap bit
  // low bits address the memory
  // wraps naturally at 2**WIDTH
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (inc) begin
      ptr <= ptr + 1'b1;
    end
  end

endmodule

// File: patch_mem_if.sv
`timescale 1ns/1ps

interface patch_mem_if;
  import query_pkg::*;

  // port 0, write only here
  // active low select
  logic      csb0;
  // active low write strobe
  logic      web0;
  mem_addr_t addr0;
  patch_t    wpatch0;

  // port 1, read only
  // active low read select
  logic      csb1;
  mem_addr_t addr1;
  // valid one cycle after the read select
  patch_t    rpatch1;

  // controller side
  modport ctrl (
    output csb0, web0, addr0, wpatch0,
    output csb1, addr1,
    input  rpatch1
  );

  // banked memory side
  modport mem (
    input  csb0, web0, addr0, wpatch0,
    input  csb1, addr1,
    output rpatch1
  );

endinterface

// File: project.f
+incdir+.
query_pkg.sv
patch_mem_if.sv
sram_1rw1r_32x256.sv
query_patch_mem.sv
patch_addr_counter.sv
query_ctrl.sv
query_buffer_top.sv
query_buffer_assert.sv
query_buffer_tb.sv

// File: query_buffer_assert.sv
`timescale 1ns/1ps
`include "query_defs.svh"

module query_buffer_assert (
  input logic              clk,
  input logic              rst_n,
  input logic              in_req,
  input logic              in_ack,
  input logic              out_req,
  input logic              out_ack,
  input query_pkg::patch_t out_patch,
  input query_pkg::count_t patch_count
);
  import query_pkg::*;

  // failures so far, summed into the testbench tally
  int fail_count = 0;

  // ack answers a request sampled on the edge before
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req))
  else begin
    fail_count++;
    $error("in_ack rose with in_req low");
  end

  // offered patch holds until the host takes it
  offer_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_req && !out_ack) |=> $stable(out_patch))
  else begin
    fail_count++;
    $error("out_patch changed while offered");
  end

  // never more than the 512 memory entries
  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    patch_count <= count_t'(1 << `QB_ADDR_WIDTH))
  else begin
    fail_count++;
    $error("patch_count above buffer depth");
  end

endmodule

bind query_buffer_top query_buffer_assert query_buffer_assert_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_req      (in_req),
  .in_ack      (in_ack),
  .out_req     (out_req),
  .out_ack     (out_ack),
  .out_patch   (out_patch),
  .patch_count (patch_count)
);

// File: query_buffer_tb.sv
`timescale 1ns/1ps
`include "query_defs.svh"

module query_buffer_tb;
  import query_pkg::*;

  // about 1150 transfers at 12 cycles or less plus margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int DEPTH          = 1 << `QB_ADDR_WIDTH;
  localparam int BURST_LEN      = 40;
  localparam int STREAM_LEN     = 600;
  localparam logic [31:0] SEED  = 32'h18aa_e4e5;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_req;
  patch_t      in_patch;
  logic        in_ack;
  logic        out_req;
  patch_t      out_patch;
  logic        out_ack;
  count_t      patch_count;

  // reference queue with the next patch due out at the front
  patch_t      model_q [$];
  int          pushes = 0;
  int          pops = 0;
  int          patch_errors = 0;
  int          count_errors = 0;
  int          flag_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  // output side holds off its ack while set
  logic        hold_out = 1'b0;
  // output handshake still open
  logic        out_busy = 1'b0;
  logic [31:0] wr_lcg = SEED;

  always #5 clk = ~clk;

  query_buffer_top query_buffer_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (in_req),
    .in_patch    (in_patch),
    .in_ack      (in_ack),
    .out_req     (out_req),
    .out_patch   (out_patch),
    .out_ack     (out_ack),
    .patch_count (patch_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic patch_t random_patch(inout logic [31:0] state);
    patch_t p;
    for (int i = 0; i < `QB_PATCH_SIZE; i++) begin
      state = lcg_next(state);
      p[i] = state[26:16];
    end
    return p;
  endfunction

  // expected front patch and pushes minus pops
  function automatic patch_t ref_expect(output count_t exp_count);
    exp_count = count_t'(pushes - pops);
    return (model_q.size() > 0) ? model_q[0] : '0;
  endfunction

  function automatic int total_errors();
    return patch_errors + count_errors + flag_errors + other_errors
           + query_buffer_top_i.query_buffer_assert_i.fail_count;
  endfunction

  task automatic check_patch(input patch_t exp, input patch_t act);
    if (act !== exp) begin
      patch_errors++;
      $display("mismatch at %0t: out_patch expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_count(input count_t exp, input count_t act);
    if (act !== exp) begin
      count_errors++;
      $display("mismatch at %0t: patch_count expected %0d, got %0d", $time, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errors++;
      $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // count against the model where both sides are settled
  task automatic check_model_count();
    count_t exp_c;
    void'(ref_expect(exp_c));
    check_count(exp_c, patch_count);
  endtask

  // four-phase write that adds the patch to the model once acked
  task automatic send_patch(input patch_t p);
    in_patch = p;
    in_req = 1'b1;
    do begin
      @(negedge clk);
    end while (!in_ack);
    model_q.push_back(p);
    pushes++;
    in_req = 1'b0;
    do begin
      @(negedge clk);
    end while (in_ack);
  endtask

  // random gap of 0 to 3 cycles before a random patch
  task automatic send_random();
    logic [1:0] gap;
    wr_lcg = lcg_next(wr_lcg);
    gap = wr_lcg[21:20];
    repeat (gap) @(negedge clk);
    send_patch(random_patch(wr_lcg));
  endtask

  // request must sit without ack while the buffer is full
  task automatic expect_blocked(input patch_t p);
    count_t exp_c;
    in_patch = p;
    in_req = 1'b1;
    repeat (16) begin
      @(negedge clk);
      if (in_ack) begin
        other_errors++;
        $display("in_ack came back at %0t while the buffer was full", $time);
      end
    end
    void'(ref_expect(exp_c));
    if (exp_c != count_t'(DEPTH)) begin
      other_errors++;
      $display("reference count %0d at %0t, buffer never filled", exp_c, $time);
    end
    check_count(exp_c, patch_count);
    in_req = 1'b0;
  endtask

  task automatic wait_drained();
    do begin
      @(negedge clk);
    end while (pushes != pops || out_req || out_busy);
  endtask

  task automatic print_counts();
    $display("errors: patch %0d, count %0d, flag %0d, other %0d, assertion %0d",
             patch_errors, count_errors, flag_errors, other_errors,
             query_buffer_top_i.query_buffer_assert_i.fail_count);
  endtask

  // output side compares each offered patch against the model
  initial begin : out_side
    patch_t      exp_p;
    count_t      exp_c;
    logic [31:0] rd_lcg;
    logic [1:0]  dly;
    out_ack = 1'b0;
    // own stream so ack delays do not shift patch values
    rd_lcg = ~SEED;
    forever begin
      @(negedge clk);
      if (rst_n && out_req) begin
        out_busy = 1'b1;
        if (model_q.size() == 0) begin
          other_errors++;
          $display("out_req raised at %0t with no patch outstanding", $time);
        end else begin
          exp_p = ref_expect(exp_c);
          check_patch(exp_p, out_patch);
          model_q.pop_front();
          pops++;
          // read pointer already moved past the offered patch
          if (!in_ack) begin
            check_count(exp_c - 1'b1, patch_count);
          end
        end
        rd_lcg = lcg_next(rd_lcg);
        dly = rd_lcg[17:16];
        while (hold_out || dly != 2'd0) begin
          // pointers and model agree while the writer is idle
          if (!in_ack) begin
            check_model_count();
          end
          if (!hold_out) begin
            dly--;
          end
          @(negedge clk);
        end
        out_ack = 1'b1;
        do begin
          @(negedge clk);
        end while (out_req);
        out_ack = 1'b0;
        out_busy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      print_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin : main_seq
    rst_n = 1'b0;
    in_req = 1'b0;
    in_patch = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset values
    check_flag("in_ack", 1'b0, in_ack);
    check_flag("out_req", 1'b0, out_req);
    check_model_count();

    // one patch round trip
    send_patch(random_patch(wr_lcg));
    wait_drained();
    check_model_count();

    // burst with back-pressure from random ack delays
    for (int i = 0; i < BURST_LEN; i++) begin
      send_random();
    end
    wait_drained();
    check_model_count();

    // fill with ack withheld while one patch parks in out_patch
    hold_out = 1'b1;
    for (int i = 0; i < DEPTH + 1; i++) begin
      send_patch(random_patch(wr_lcg));
    end
    expect_blocked(random_patch(wr_lcg));
    hold_out = 1'b0;
    wait_drained();
    check_model_count();

    // long stream that wraps both pointers
    for (int i = 0; i < STREAM_LEN; i++) begin
      send_random();
    end
    wait_drained();
    check_model_count();

    print_counts();
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: query_buffer_top.sv
`timescale 1ns/1ps

module query_buffer_top (
  input  logic              clk,
  input  logic              rst_n,
  // I/O side
  input  logic              in_req,
  input  query_pkg::patch_t in_patch,
  output logic              in_ack,
  // compute side
  output logic              out_req,
  output query_pkg::patch_t out_patch,
  input  logic              out_ack,
  output query_pkg::count_t patch_count
);
  import query_pkg::*;

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  logic wr_inc;
  logic rd_inc;

  // both memory ports between controller and banks
  patch_mem_if mem_if ();

  query_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (in_req),
    .in_patch    (in_patch),
    .in_ack      (in_ack),
    .out_req     (out_req),
    .out_patch   (out_patch),
    .out_ack     (out_ack),
    .patch_count (patch_count),
    .wr_ptr      (wr_ptr),
    .rd_ptr      (rd_ptr),
    .wr_inc      (wr_inc),
    .rd_inc      (rd_inc),
    .mem         (mem_if.ctrl)
  );

  // write pointer
  patch_addr_counter #(.WIDTH($bits(ptr_t))) wr_ptr_i (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (wr_inc),
    .ptr   (wr_ptr)
  );

  // read pointer
  patch_addr_counter #(.WIDTH($bits(ptr_t))) rd_ptr_i (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (rd_inc),
    .ptr   (rd_ptr)
  );

  query_patch_mem mem_i (
    .clk (clk),
    .mem (mem_if.mem)
  );

endmodule

// File: query_ctrl.sv
`timescale 1ns/1ps

module query_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  // I/O side, host requests
  input  logic                in_req,
  input  query_pkg::patch_t   in_patch,
  output logic                in_ack,
  // compute side, DUT requests
  output logic                out_req,
  output query_pkg::patch_t   out_patch,
  input  logic                out_ack,
  output query_pkg::count_t   patch_count,
  // pointer counters
  input  query_pkg::ptr_t     wr_ptr,
  input  query_pkg::ptr_t     rd_ptr,
  output logic                wr_inc,
  output logic                rd_inc,
  patch_mem_if.ctrl           mem
);
  import query_pkg::*;

  localparam int AW = $bits(mem_addr_t);

  wr_state_e wr_state;
  wr_state_e wr_state_nxt;
  rd_state_e rd_state;
  rd_state_e rd_state_nxt;
  logic      full;
  logic      empty;
  logic      wr_fire;
  logic      rd_fire;

  // same address, opposite laps
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // write lands on the edge that sees in_req
  assign wr_fire = (wr_state == W_IDLE) && in_req && !full;
  // read issued straight from idle
  assign rd_fire = (rd_state == R_IDLE) && !empty;

  assign wr_inc = wr_fire;
  assign rd_inc = rd_fire;

  // port 0 is write only, strobe follows select
  assign mem.csb0    = !wr_fire;
  assign mem.web0    = !wr_fire;
  assign mem.addr0   = wr_ptr[AW-1:0];
  assign mem.wpatch0 = in_patch;

  assign mem.csb1  = !rd_fire;
  assign mem.addr1 = rd_ptr[AW-1:0];

  // write handshake
  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      W_IDLE: begin
        // full leaves in_req waiting, no ack
        if (wr_fire) begin
          wr_state_nxt = W_ACK;
        end
      end
      W_ACK: begin
        // hold ack until host lets go
        if (!in_req) begin
          wr_state_nxt = W_IDLE;
        end
      end
      default: wr_state_nxt = W_IDLE;
    endcase
  end

  // read handshake
  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      R_IDLE: begin
        if (rd_fire) begin
          rd_state_nxt = R_WAIT;
        end
      end
      // macro data arrives here
      R_WAIT: rd_state_nxt = R_OFFER;
      R_OFFER: begin
        // back-pressure, hold until ack
        if (out_ack) begin
          rd_state_nxt = R_DROP;
        end
      end
      R_DROP: begin
        // host must release ack first
        if (!out_ack) begin
          rd_state_nxt = R_IDLE;
        end
      end
      default: rd_state_nxt = R_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= W_IDLE;
      rd_state <= R_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
      rd_state <= rd_state_nxt;
    end
  end

  // capture returned patch, stable through the offer
  always_ff @(posedge clk) begin
    if (rd_state == R_WAIT) begin
      out_patch <= mem.rpatch1;
    end
  end

  assign in_ack  = (wr_state == W_ACK);
  assign out_req = (rd_state == R_OFFER);

  // lap bit makes the difference exact up to 512
  assign patch_count = count_t'(wr_ptr - rd_ptr);

endmodule

// File: query_defs.svh
`ifndef QUERY_DEFS_SVH
`define QUERY_DEFS_SVH

// patch element width, one pixel feature
`define QB_ELEM_WIDTH 11

// elements per query patch
`define QB_PATCH_SIZE 5

// patch address, 512 entries over two banks
`define QB_ADDR_WIDTH 9

// data width of one sram macro
`define QB_MACRO_WIDTH 32

// entries per macro, 256 deep
`define QB_MACRO_ADDR_WIDTH 8

`endif

// File: query_patch_mem.sv
`timescale 1ns/1ps
`include "query_defs.svh"

module query_patch_mem (
  input logic       clk,
  patch_mem_if.mem  mem
);
  import query_pkg::*;

  localparam int PATCH_W = $bits(patch_t);
  localparam int WORD_W  = 2 * `QB_MACRO_WIDTH;
  localparam int MW      = `QB_MACRO_WIDTH;
  // address bit that picks the bank
  localparam int BANK_BIT = `QB_MACRO_ADDR_WIDTH;

  // patch zero-padded to two macro words
  logic [WORD_W-1:0] wword;
  // per-bank active low selects
  logic [1:0]        bank_csb0;
  logic [1:0]        bank_csb1;
  // read words from each bank
  logic [WORD_W-1:0] rword [2];
  // bank of the last issued read
  logic              rd_bank_q;

  assign wword = {{(WORD_W - PATCH_W){1'b0}}, mem.wpatch0};

  // bank 0 for addresses below 256, bank 1 above
  // selects stay high unless the port is selected
  assign bank_csb0[0] = mem.csb0 | mem.addr0[BANK_BIT];
  assign bank_csb0[1] = mem.csb0 | ~mem.addr0[BANK_BIT];
  assign bank_csb1[0] = mem.csb1 | mem.addr1[BANK_BIT];
  assign bank_csb1[1] = mem.csb1 | ~mem.addr1[BANK_BIT];

  // two macros side by side per bank
  for (genvar b = 0; b < 2; b++) begin : g_bank
    // low half, patch bits 31:0
    sram_1rw1r_32x256 lo_i (
      .clk0  (clk),
      .csb0  (bank_csb0[b]),
      .web0  (mem.web0),
      .addr0 (mem.addr0[BANK_BIT-1:0]),
      .din0  (wword[MW-1:0]),
      .dout0 (),
      .clk1  (clk),
      .csb1  (bank_csb1[b]),
      .addr1 (mem.addr1[BANK_BIT-1:0]),
      .dout1 (rword[b][MW-1:0])
    );

    // high half, upper patch bits plus padding
    sram_1rw1r_32x256 hi_i (
      .clk0  (clk),
      .csb0  (bank_csb0[b]),
      .web0  (mem.web0),
      .addr0 (mem.addr0[BANK_BIT-1:0]),
      .din0  (wword[WORD_W-1:MW]),
      .dout0 (),
      .clk1  (clk),
      .csb1  (bank_csb1[b]),
      .addr1 (mem.addr1[BANK_BIT-1:0]),
      .dout1 (rword[b][WORD_W-1:MW])
    );
  end

  // bank select delayed to line up with macro data
  // only updated on a read, so rpatch1 holds like the macros
  always_ff @(posedge clk) begin
    if (!mem.csb1) begin
      rd_bank_q <= mem.addr1[BANK_BIT];
    end
  end

  // drop the padding on the way out
  assign mem.rpatch1 = patch_t'(rword[rd_bank_q][PATCH_W-1:0]);

endmodule

// File: query_pkg.sv
`include "query_defs.svh"

package query_pkg;

  // one element of a query patch
  typedef logic [`QB_ELEM_WIDTH-1:0] elem_t;

  // element 0 sits in the low bits
  typedef elem_t [`QB_PATCH_SIZE-1:0] patch_t;

  // patch address, top bit is the bank
  typedef logic [`QB_ADDR_WIDTH-1:0] mem_addr_t;

  // address plus lap bit
  typedef logic [`QB_ADDR_WIDTH:0] ptr_t;

  // occupancy, 0 to 512 inclusive
  typedef logic [`QB_ADDR_WIDTH:0] count_t;

  // write side handshake
  typedef enum logic {W_IDLE, W_ACK} wr_state_e;

  // read side handshake
  typedef enum logic [1:0] {R_IDLE, R_WAIT, R_OFFER, R_DROP} rd_state_e;

endpackage

// File: sram_1rw1r_32x256.sv
`timescale 1ns/1ps
`include "query_defs.svh"

module sram_1rw1r_32x256 (
  // port 0, read/write
  input  logic                            clk0,
  input  logic                            csb0,
  input  logic                            web0,
  input  logic [`QB_MACRO_ADDR_WIDTH-1:0] addr0,
  input  logic [`QB_MACRO_WIDTH-1:0]      din0,
  output logic [`QB_MACRO_WIDTH-1:0]      dout0,
  // port 1, read only
  input  logic                            clk1,
  input  logic                            csb1,
  input  logic [`QB_MACRO_ADDR_WIDTH-1:0] addr1,
  output logic [`QB_MACRO_WIDTH-1:0]      dout1
);

  // behavioral stand-in for the sky130 macro
  logic [`QB_MACRO_WIDTH-1:0] ram [2**`QB_MACRO_ADDR_WIDTH];

  // port 0 write or registered read
  always_ff @(posedge clk0) begin
    if (!csb0) begin
      if (!web0) begin
        ram[addr0] <= din0;
      end else begin
        dout0 <= ram[addr0];
      end
    end
  end

  // port 1 registered read
  // output holds between reads
  always_ff @(posedge clk1) begin
    if (!csb1) begin
      dout1 <= ram[addr1];
    end
  end

endmodule
